// ==== pitaya_pkg.sv ====
////////////////////////////////////////
// widths, types and register map shared
// by the fast-ADC board top level
////////////////////////////////////////
`default_nettype none

package pitaya_pkg;

  ////////////////////////////////////////
  // widths and channel counts
  ////////////////////////////////////////
  localparam int ADC_DW = 14;  // converter resolution
  localparam int ADC_CH = 4;
  localparam int PDM_CH = 4;   // slow analog outputs
  localparam int PDM_DW = 8;
  localparam int EXP_W  = 11;  // pins per expansion bank
  localparam int BUS_AW = 20;
  localparam int BUS_DW = 32;

  typedef logic        [ADC_DW-1:0] adc_raw_t;     // unsigned, negative slope
  typedef logic signed [ADC_DW-1:0] adc_sample_t;  // two's complement
  typedef logic        [PDM_DW-1:0] pdm_level_t;
  typedef logic        [EXP_W-1:0]  exp_bank_t;
  typedef logic        [BUS_AW-1:0] bus_addr_t;
  typedef logic        [BUS_DW-1:0] bus_data_t;

  ////////////////////////////////////////
  // housekeeping register map, byte offsets
  ////////////////////////////////////////
  localparam bus_addr_t REG_ID        = 20'h00;  // read only
  localparam bus_addr_t REG_EXP_P_DIR = 20'h10;
  localparam bus_addr_t REG_EXP_N_DIR = 20'h14;
  localparam bus_addr_t REG_EXP_P_OUT = 20'h18;
  localparam bus_addr_t REG_EXP_N_OUT = 20'h1C;
  localparam bus_addr_t REG_EXP_P_IN  = 20'h20;  // read only
  localparam bus_addr_t REG_EXP_N_IN  = 20'h24;  // read only
  localparam bus_addr_t REG_PDM_BASE  = 20'h30;  // channel k at +4k

  // board identification word
  localparam bus_data_t HK_ID = 32'h0000_4ADC;

endpackage : pitaya_pkg

`default_nettype wire

// ==== adc_format.sv ====
////////////////////////////////////////
// raw ADC code to two's complement, two
// register stages, one sample per clock
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module adc_format
  import pitaya_pkg::*;
#(
  parameter int N_CH = 4  // number of converter channels
)(
  input  wire                        adc_clk_01,
  input  wire                        rst_i,
  input  wire adc_raw_t [N_CH-1:0]   adc_raw_i,   // straight from the pads
  output adc_sample_t   [N_CH-1:0]   adc_dat_o    // two cycles later
);

  adc_sample_t [N_CH-1:0] fmt;    // combinational conversion
  adc_sample_t [N_CH-1:0] fmt_r;  // first pipeline stage

  // converter delivers an unsigned code falling with input voltage
  // sign bit stays, magnitude bits flip -> two's complement
  always_comb begin
    for (int ch = 0; ch < N_CH; ch++) begin
      fmt[ch] = {adc_raw_i[ch][ADC_DW-1], ~adc_raw_i[ch][ADC_DW-2:0]};
    end
  end

  ////////////////////////////////////////
  // capture pipeline
  ////////////////////////////////////////

  always_ff @(posedge adc_clk_01) begin
    if (rst_i) begin
      fmt_r     <= '0;
      adc_dat_o <= '0;
    end else begin
      fmt_r     <= fmt;    // stage 1, edge n
      adc_dat_o <= fmt_r;  // stage 2, edge n+1
    end
  end

endmodule : adc_format

`default_nettype wire

// ==== pdm_gen.sv ====
////////////////////////////////////////
// first-order pulse-density modulators,
// one accumulator per analog output pin
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module pdm_gen
  import pitaya_pkg::*;
#(
  parameter int N_CH = 4,    // output channels
  parameter int RNG  = 255   // full-scale level, one period in clocks
)(
  input  wire                         adc_clk_01,
  input  wire                         rst_i,
  input  wire pdm_level_t [N_CH-1:0]  pdm_cfg_i,  // levels from register block
  output logic            [N_CH-1:0]  pdm_o       // to the RC filters
);

  // holds acc + level, worst case 2*RNG-1
  localparam int AW = $clog2(2 * RNG);

  logic [N_CH-1:0][AW-1:0] acc_r;  // residue, always below RNG
  logic [N_CH-1:0][AW-1:0] sum;
  logic [N_CH-1:0]         wrap;   // sum reached full scale

  always_comb begin
    for (int ch = 0; ch < N_CH; ch++) begin
      sum[ch]  = acc_r[ch] + AW'(pdm_cfg_i[ch]);
      wrap[ch] = (sum[ch] >= AW'(RNG));
    end
  end

  ////////////////////////////////////////
  // accumulators and output bits
  ////////////////////////////////////////

  // over any RNG clocks the residue can drift by less than RNG,
  // so the count of wraps is exactly the level
  always_ff @(posedge adc_clk_01) begin
    if (rst_i) begin
      acc_r <= '0;
      pdm_o <= '0;
    end else begin
      for (int ch = 0; ch < N_CH; ch++) begin
        if (wrap[ch]) begin
          acc_r[ch] <= sum[ch] - AW'(RNG);  // give back one full scale
        end else begin
          acc_r[ch] <= sum[ch];
        end
        pdm_o[ch] <= wrap[ch];  // one pulse per wrap
      end
    end
  end

endmodule : pdm_gen

`default_nettype wire

// ==== exp_gpio.sv ====
////////////////////////////////////////
// expansion connector p/n banks, output
// gating and input synchronizers
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module exp_gpio
  import pitaya_pkg::*;
#(
  parameter int W = 11  // pins used per bank
)(
  input  wire            adc_clk_01,
  input  wire            rst_i,
  input  wire exp_bank_t exp_p_in_i,   // pad inputs, asynchronous
  input  wire exp_bank_t exp_n_in_i,
  input  wire exp_bank_t p_dir_i,      // 1 = pin drives
  input  wire exp_bank_t n_dir_i,
  input  wire exp_bank_t p_out_i,
  input  wire exp_bank_t n_out_i,
  output exp_bank_t      exp_p_out_o,
  output exp_bank_t      exp_n_out_o,
  output exp_bank_t      exp_p_oe_o,
  output exp_bank_t      exp_n_oe_o,
  output exp_bank_t      p_in_sync_o,  // readback, two flops late
  output exp_bank_t      n_in_sync_o
);

  exp_bank_t p_meta_r, n_meta_r;  // first synchronizer stage

  // data only on driven pins, low on inputs
  always_comb begin
    exp_p_out_o = '0;
    exp_n_out_o = '0;
    for (int b = 0; b < W; b++) begin
      exp_p_out_o[b] = p_dir_i[b] & p_out_i[b];
      exp_n_out_o[b] = n_dir_i[b] & n_out_i[b];
    end
  end

  assign exp_p_oe_o = p_dir_i;  // direction is the pad enable
  assign exp_n_oe_o = n_dir_i;

  always_ff @(posedge adc_clk_01) begin
    if (rst_i) begin
      p_meta_r    <= '0;
      n_meta_r    <= '0;
      p_in_sync_o <= '0;
      n_in_sync_o <= '0;
    end else begin
      p_meta_r    <= exp_p_in_i;
      n_meta_r    <= exp_n_in_i;
      p_in_sync_o <= p_meta_r;  // settled copy
      n_in_sync_o <= n_meta_r;
    end
  end

endmodule : exp_gpio

`default_nettype wire

// ==== hk_regs.sv ====
////////////////////////////////////////
// housekeeping registers behind a single
// req/ack bus slave, GPIO and PDM config
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module hk_regs
  import pitaya_pkg::*;
(
  input  wire                          adc_clk_01,
  input  wire                          rst_i,
  // system bus, four-phase handshake
  input  wire                          bus_req_i,
  input  wire                          bus_wen_i,
  input  wire bus_addr_t               bus_addr_i,
  input  wire bus_data_t               bus_wdata_i,
  output logic                         bus_ack_o,
  output bus_data_t                    bus_rdata_o,
  output logic                         bus_err_o,
  // expansion connector
  input  wire exp_bank_t               p_in_sync_i,
  input  wire exp_bank_t               n_in_sync_i,
  output exp_bank_t                    p_dir_o,
  output exp_bank_t                    n_dir_o,
  output exp_bank_t                    p_out_o,
  output exp_bank_t                    n_out_o,
  // analog output levels
  output pdm_level_t [PDM_CH-1:0]      pdm_cfg_o
);

  logic              acc_go;   // new access starts
  logic [PDM_CH-1:0] pdm_sel;  // one-hot PDM level decode
  bus_data_t         rd_data;
  logic              rd_err;   // offset not mapped

  // req high while ack still low is a fresh request,
  // ack high blocks anything else until req has dropped
  assign acc_go = bus_req_i & ~bus_ack_o;

  always_comb begin
    for (int k = 0; k < PDM_CH; k++) begin
      pdm_sel[k] = (bus_addr_i == REG_PDM_BASE + bus_addr_t'(4 * k));
    end
  end

  ////////////////////////////////////////
  // read decode
  ////////////////////////////////////////

  always_comb begin
    rd_data = '0;
    rd_err  = 1'b0;
    case (bus_addr_i)
      REG_ID:        rd_data = HK_ID;
      REG_EXP_P_DIR: rd_data = {{(BUS_DW-EXP_W){1'b0}}, p_dir_o};
      REG_EXP_N_DIR: rd_data = {{(BUS_DW-EXP_W){1'b0}}, n_dir_o};
      REG_EXP_P_OUT: rd_data = {{(BUS_DW-EXP_W){1'b0}}, p_out_o};
      REG_EXP_N_OUT: rd_data = {{(BUS_DW-EXP_W){1'b0}}, n_out_o};
      REG_EXP_P_IN:  rd_data = {{(BUS_DW-EXP_W){1'b0}}, p_in_sync_i};
      REG_EXP_N_IN:  rd_data = {{(BUS_DW-EXP_W){1'b0}}, n_in_sync_i};
      default: begin
        rd_err = ~|pdm_sel;  // only the PDM window is left
        for (int k = 0; k < PDM_CH; k++) begin
          if (pdm_sel[k]) begin
            rd_data = {{(BUS_DW-PDM_DW){1'b0}}, pdm_cfg_o[k]};
          end
        end
      end
    endcase
  end

  ////////////////////////////////////////
  // write side
  ////////////////////////////////////////

  always_ff @(posedge adc_clk_01) begin
    if (rst_i) begin
      p_dir_o   <= '0;
      n_dir_o   <= '0;
      p_out_o   <= '0;
      n_out_o   <= '0;
      pdm_cfg_o <= '0;
    end else if (acc_go && bus_wen_i) begin
      case (bus_addr_i)
        REG_EXP_P_DIR: p_dir_o <= bus_wdata_i[EXP_W-1:0];
        REG_EXP_N_DIR: n_dir_o <= bus_wdata_i[EXP_W-1:0];
        REG_EXP_P_OUT: p_out_o <= bus_wdata_i[EXP_W-1:0];
        REG_EXP_N_OUT: n_out_o <= bus_wdata_i[EXP_W-1:0];
        default: ;  // ID, IN banks and holes keep their value
      endcase
      for (int k = 0; k < PDM_CH; k++) begin
        if (pdm_sel[k]) begin
          pdm_cfg_o[k] <= bus_wdata_i[PDM_DW-1:0];  // seen by pdm_gen next edge
        end
      end
    end
  end

  ////////////////////////////////////////
  // handshake
  ////////////////////////////////////////

  always_ff @(posedge adc_clk_01) begin
    if (rst_i) begin
      bus_ack_o   <= 1'b0;
      bus_err_o   <= 1'b0;
      bus_rdata_o <= '0;
    end else if (acc_go) begin
      bus_ack_o   <= 1'b1;     // one cycle after req seen high
      bus_rdata_o <= rd_data;
      bus_err_o   <= rd_err;
    end else if (!bus_req_i && bus_ack_o) begin
      bus_ack_o <= 1'b0;       // master released req
      bus_err_o <= 1'b0;
    end
  end

endmodule : hk_regs

`default_nettype wire

// ==== pitaya_top.sv ====
////////////////////////////////////////
// board top, ADC formatting, PDM outputs,
// expansion GPIO and housekeeping slave
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module pitaya_top
  import pitaya_pkg::*;
#(
  parameter int PDM_RNG = 255  // PDM full scale
)(
  input  wire                          adc_clk_01,
  input  wire                          rst_i,
  // ADC
  input  wire adc_raw_t [ADC_CH-1:0]   adc_raw_i,
  output wire adc_sample_t [ADC_CH-1:0] adc_dat_o,
  // slow analog outputs
  output wire [PDM_CH-1:0]             dac_pdm_o,
  // expansion connector, pad tristate split outside
  input  wire exp_bank_t               exp_p_in_i,
  input  wire exp_bank_t               exp_n_in_i,
  output wire exp_bank_t               exp_p_out_o,
  output wire exp_bank_t               exp_n_out_o,
  output wire exp_bank_t               exp_p_oe_o,
  output wire exp_bank_t               exp_n_oe_o,
  // system bus
  input  wire                          bus_req_i,
  input  wire                          bus_wen_i,
  input  wire bus_addr_t               bus_addr_i,
  input  wire bus_data_t               bus_wdata_i,
  output wire                          bus_ack_o,
  output wire bus_data_t               bus_rdata_o,
  output wire                          bus_err_o
);

  pdm_level_t [PDM_CH-1:0] pdm_cfg;
  exp_bank_t               p_dir, n_dir;          // drive enables
  exp_bank_t               p_out, n_out;
  exp_bank_t               p_in_sync, n_in_sync;  // synchronized readback

  adc_format #(.N_CH (ADC_CH)) i_adc_format (
    .adc_clk_01 (adc_clk_01),
    .rst_i      (rst_i     ),
    .adc_raw_i  (adc_raw_i ),
    .adc_dat_o  (adc_dat_o )
  );

  pdm_gen #(.N_CH (PDM_CH), .RNG (PDM_RNG)) i_pdm_gen (
    .adc_clk_01 (adc_clk_01),
    .rst_i      (rst_i     ),
    .pdm_cfg_i  (pdm_cfg   ),
    .pdm_o      (dac_pdm_o )
  );

  exp_gpio #(.W (EXP_W)) i_exp_gpio (
    .adc_clk_01  (adc_clk_01 ),
    .rst_i       (rst_i      ),
    .exp_p_in_i  (exp_p_in_i ),
    .exp_n_in_i  (exp_n_in_i ),
    .p_dir_i     (p_dir      ),
    .n_dir_i     (n_dir      ),
    .p_out_i     (p_out      ),
    .n_out_i     (n_out      ),
    .exp_p_out_o (exp_p_out_o),
    .exp_n_out_o (exp_n_out_o),
    .exp_p_oe_o  (exp_p_oe_o ),
    .exp_n_oe_o  (exp_n_oe_o ),
    .p_in_sync_o (p_in_sync  ),
    .n_in_sync_o (n_in_sync  )
  );

  hk_regs i_hk_regs (
    .adc_clk_01  (adc_clk_01 ),
    .rst_i       (rst_i      ),
    .bus_req_i   (bus_req_i  ),
    .bus_wen_i   (bus_wen_i  ),
    .bus_addr_i  (bus_addr_i ),
    .bus_wdata_i (bus_wdata_i),
    .bus_ack_o   (bus_ack_o  ),
    .bus_rdata_o (bus_rdata_o),
    .bus_err_o   (bus_err_o  ),
    .p_in_sync_i (p_in_sync  ),
    .n_in_sync_i (n_in_sync  ),
    .p_dir_o     (p_dir      ),
    .n_dir_o     (n_dir      ),
    .p_out_o     (p_out      ),
    .n_out_o     (n_out      ),
    .pdm_cfg_o   (pdm_cfg    )
  );

endmodule : pitaya_top

`default_nettype wire

// ==== tb_pitaya_top.sv ====
////////////////////////////////////////
// self-checking testbench for pitaya_top, steps read
// from pitaya_tests.txt, then random ADC and GPIO traffic
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_pitaya_top
  import pitaya_pkg::*;
;

  localparam int PDM_RNG = 255;  // PDM full scale, one count window
  localparam int BUS_TMO = 50;   // cycles before a bus wait gives up
  localparam int RND_N   = 16;   // back-to-back random ADC words

  int seed = 32'h91d0;

  logic                     adc_clk_01;
  logic                     rst_i;
  adc_raw_t    [ADC_CH-1:0] adc_raw;
  adc_sample_t [ADC_CH-1:0] adc_dat;
  logic        [PDM_CH-1:0] dac_pdm;
  exp_bank_t                exp_p_in, exp_n_in;
  exp_bank_t                exp_p_out, exp_n_out;
  exp_bank_t                exp_p_oe, exp_n_oe;
  logic                     bus_req, bus_wen;
  bus_addr_t                bus_addr;
  bus_data_t                bus_wdata;
  logic                     bus_ack;
  bus_data_t                bus_rdata;
  logic                     bus_err;

  // written GPIO registers, index 0 = p bank, 1 = n bank
  exp_bank_t                dir_mdl [2];
  exp_bank_t                out_mdl [2];

  pitaya_top #(.PDM_RNG (PDM_RNG)) i_dut (
    .adc_clk_01  (adc_clk_01),
    .rst_i       (rst_i     ),
    .adc_raw_i   (adc_raw   ),
    .adc_dat_o   (adc_dat   ),
    .dac_pdm_o   (dac_pdm   ),
    .exp_p_in_i  (exp_p_in  ),
    .exp_n_in_i  (exp_n_in  ),
    .exp_p_out_o (exp_p_out ),
    .exp_n_out_o (exp_n_out ),
    .exp_p_oe_o  (exp_p_oe  ),
    .exp_n_oe_o  (exp_n_oe  ),
    .bus_req_i   (bus_req   ),
    .bus_wen_i   (bus_wen   ),
    .bus_addr_i  (bus_addr  ),
    .bus_wdata_i (bus_wdata ),
    .bus_ack_o   (bus_ack   ),
    .bus_rdata_o (bus_rdata ),
    .bus_err_o   (bus_err   )
  );

  initial begin
    adc_clk_01 = 1'b0;
    forever #5 adc_clk_01 = ~adc_clk_01;  // 100 MHz
  end

  ////////////////////////////////////////
  // failure reporting and compares
  ////////////////////////////////////////

  task automatic abort_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_sample(input string name, input adc_sample_t exp, input adc_sample_t act);
    if (act !== exp) begin
      $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_word(input string name, input bus_data_t exp, input bus_data_t act);
    if (act !== exp) begin
      $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bank(input string name, input exp_bank_t exp, input exp_bank_t act);
    if (act !== exp) begin
      $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("ERR t=%0t %s expected %0d actual %0d", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR t=%0t %s expected %b actual %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  // top bit stays, the magnitude bits flip
  function automatic adc_sample_t expect_sample(input adc_raw_t raw);
    return adc_sample_t'(raw ^ adc_raw_t'({1'b0, {(ADC_DW-1){1'b1}}}));
  endfunction

  // keeps the expected GPIO register contents
  task automatic model_write(input bus_addr_t addr, input exp_bank_t data);
    case (addr)
      REG_EXP_P_DIR: dir_mdl[0] = data;
      REG_EXP_N_DIR: dir_mdl[1] = data;
      REG_EXP_P_OUT: out_mdl[0] = data;
      REG_EXP_N_OUT: out_mdl[1] = data;
      default: ;  // no pad effect
    endcase
  endtask

  // oe follows direction, data only where a pin drives
  task automatic verify_pads();
    check_bank("exp_p_oe_o", dir_mdl[0], exp_p_oe);
    check_bank("exp_p_out_o", dir_mdl[0] & out_mdl[0], exp_p_out);
    check_bank("exp_n_oe_o", dir_mdl[1], exp_n_oe);
    check_bank("exp_n_out_o", dir_mdl[1] & out_mdl[1], exp_n_out);
  endtask

  ////////////////////////////////////////
  // four-phase bus master
  ////////////////////////////////////////

  // called and returns 1 ns after a rising edge
  task automatic wait_ack(input logic level, output int cycles);
    cycles = 0;
    do begin
      @(posedge adc_clk_01);
      #1;
      cycles++;
    end while (bus_ack !== level && cycles < BUS_TMO);
    if (bus_ack !== level) begin
      $display("bus timeout, ack not at %0b after %0d cycles", level, BUS_TMO);
      abort_run();
    end
  endtask

  task automatic bus_access(input logic wen, input bus_addr_t addr, input bus_data_t wdata,
                            output bus_data_t rdata, output logic err);
    int cycles;
    bus_wen   = wen;
    bus_addr  = addr;
    bus_wdata = wdata;
    bus_req   = 1'b1;
    wait_ack(1'b1, cycles);
    if (cycles != 1) begin
      $display("ack rose %0d cycles after req instead of one", cycles);
      abort_run();
    end
    rdata   = bus_rdata;  // valid together with ack
    err     = bus_err;
    bus_req = 1'b0;
    wait_ack(1'b0, cycles);
    if (cycles != 1) begin
      $display("ack fell %0d cycles after req dropped instead of one", cycles);
      abort_run();
    end
    @(posedge adc_clk_01);  // idle cycle, req still low
    #1;
    check_flag("bus_ack_o", 1'b0, bus_ack);
  endtask

  ////////////////////////////////////////
  // one line of the test file
  ////////////////////////////////////////

  task automatic run_step(input string kind, input logic [31:0] a, b, c);
    bus_data_t rdata;
    logic      err;
    int        ones;
    if (kind == "ADC") begin
      adc_raw[a[1:0]] = b[ADC_DW-1:0];
      repeat (2) begin  // two register stages
        @(posedge adc_clk_01);
        #1;
      end
      check_sample($sformatf("adc_dat_o[%0d]", a[1:0]), adc_sample_t'(c[ADC_DW-1:0]),
                   adc_dat[a[1:0]]);
    end else if (kind == "WR") begin
      bus_access(1'b1, a[BUS_AW-1:0], b, rdata, err);
      check_flag("bus_err_o", c[0], err);
      model_write(a[BUS_AW-1:0], b[EXP_W-1:0]);
      verify_pads();
    end else if (kind == "RD") begin
      bus_access(1'b0, a[BUS_AW-1:0], '0, rdata, err);
      check_word("bus_rdata_o", b, rdata);
      check_flag("bus_err_o", c[0], err);
    end else if (kind == "OUT") begin
      check_bank(a[0] ? "exp_n_oe_o" : "exp_p_oe_o", b[EXP_W-1:0], a[0] ? exp_n_oe : exp_p_oe);
      check_bank(a[0] ? "exp_n_out_o" : "exp_p_out_o", c[EXP_W-1:0],
                 a[0] ? exp_n_out : exp_p_out);
    end else if (kind == "PIN") begin
      if (a[0]) begin
        exp_n_in = b[EXP_W-1:0];
      end else begin
        exp_p_in = b[EXP_W-1:0];
      end
      repeat (3) begin  // past the synchronizer
        @(posedge adc_clk_01);
        #1;
      end
      bus_access(1'b0, a[0] ? REG_EXP_N_IN : REG_EXP_P_IN, '0, rdata, err);
      check_bank("bus_rdata_o", c[EXP_W-1:0], rdata[EXP_W-1:0]);
    end else if (kind == "PDM") begin
      bus_access(1'b1, REG_PDM_BASE + bus_addr_t'({a[1:0], 2'b00}), b, rdata, err);
      check_flag("bus_err_o", 1'b0, err);
      ones = 0;
      repeat (2) begin
        @(posedge adc_clk_01);
        #1;
      end
      repeat (PDM_RNG) begin  // one full window
        @(posedge adc_clk_01);
        #1;
        if (dac_pdm[a[1:0]]) ones++;
      end
      check_count($sformatf("dac_pdm_o[%0d] ones", a[1:0]), int'(c), ones);
    end else begin
      $display("unknown step kind %s in test file", kind);
      abort_run();
    end
  endtask

  // new words every cycle, each checked two cycles on
  task automatic run_random_adc();
    adc_raw_t [ADC_CH-1:0] sent [RND_N];
    logic [31:0]           r;
    for (int i = 0; i < RND_N + 2; i++) begin
      if (i >= 2) begin
        for (int ch = 0; ch < ADC_CH; ch++) begin
          check_sample($sformatf("adc_dat_o[%0d]", ch), expect_sample(sent[i-2][ch]),
                       adc_dat[ch]);
        end
      end
      if (i < RND_N) begin
        for (int ch = 0; ch < ADC_CH; ch++) begin
          r = $random(seed);
          sent[i][ch] = r[ADC_DW-1:0];
        end
        adc_raw = sent[i];
      end
      @(posedge adc_clk_01);
      #1;
    end
  endtask

  // random direction and data on both banks, pads checked after every write
  task automatic run_random_gpio();
    bus_addr_t   gpio_regs [4] = '{REG_EXP_P_DIR, REG_EXP_N_DIR, REG_EXP_P_OUT, REG_EXP_N_OUT};
    bus_data_t   rdata;
    logic        err;
    logic [31:0] r;
    logic [1:0]  sel;
    for (int i = 0; i < RND_N; i++) begin
      sel = 2'(i);
      r   = $random(seed);
      bus_access(1'b1, gpio_regs[sel], r, rdata, err);
      check_flag("bus_err_o", 1'b0, err);
      model_write(gpio_regs[sel], r[EXP_W-1:0]);
      verify_pads();
    end
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    int          fd;
    int          n;
    string       line;
    string       kind;
    logic [31:0] a, b, c;
    rst_i     = 1'b1;
    adc_raw   = '0;
    exp_p_in  = '0;
    exp_n_in  = '0;
    bus_req   = 1'b0;
    bus_wen   = 1'b0;
    bus_addr  = '0;
    bus_wdata = '0;
    dir_mdl   = '{'0, '0};  // registers clear after reset
    out_mdl   = '{'0, '0};
    repeat (10) @(posedge adc_clk_01);
    #1;
    rst_i = 1'b0;
    fd = $fopen("pitaya_tests.txt", "r");
    if (fd == 0) begin
      $display("cannot open pitaya_tests.txt");
      abort_run();
    end
    while ($fgets(line, fd) != 0) begin
      n = $sscanf(line, "%s %h %h %h", kind, a, b, c);
      if (n < 1 || kind == "#") continue;  // blank or comment
      if (n != 4) begin
        $display("malformed test line: %s", line);
        abort_run();
      end
      run_step(kind, a, b, c);
    end
    $fclose(fd);
    run_random_adc();
    run_random_gpio();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule : tb_pitaya_top

`default_nettype wire

// ==== pitaya_tests.txt ====
# kind op1 op2 op3, all hex: ADC ch raw sample | WR addr data err | RD addr data err
# OUT bank oe out | PIN bank pins readback | PDM ch level ones (bank 0 = p, 1 = n)
RD 0 4adc 0
ADC 0 0000 1fff
ADC 1 3fff 2000
ADC 2 2000 3fff
ADC 3 1fff 0000
ADC 0 0123 1edc
WR 10 00f 0
WR 18 5a5 0
RD 10 00f 0
RD 18 5a5 0
OUT 0 00f 005
WR 14 7f0 0
RD 14 7f0 0
RD 40 0 1
RD 8 0 1
PIN 0 2a5 2a5
WR 20 7ff 0
RD 20 2a5 0
PIN 1 155 155
PDM 0 00 00
PDM 1 01 01
PDM 2 80 80
PDM 3 ff ff
RD 38 80 0

// ==== sources.f ====
pitaya_pkg.sv
adc_format.sv
pdm_gen.sv
exp_gpio.sv
hk_regs.sv
pitaya_top.sv
tb_pitaya_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it, and decides pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -f sources.f --top-module tb_pitaya_top -Mdir obj_dir -o sim_tb \
  && ./obj_dir/sim_tb | tee sim.log \
  || { echo "build or run failed"; exit 1; }

grep -q "Simulation finished: PASS" sim.log \
  && echo "result: pass" \
  || { echo "result: fail"; exit 1; }
